/* hw/maze_pkg.sv */
package maze_pkg;

	typedef logic [9:0] coord_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t w;
		coord_t h;
	} rect_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pos_t;

	typedef enum logic [1:0] {
		LEVEL_NONE = 2'd0,
		LEVEL_1    = 2'd1,
		LEVEL_2    = 2'd2,
		LEVEL_3    = 2'd3
	} level_t;

	typedef enum logic [2:0] {
		S_IDLE   = 3'd0,
		S_SELECT = 3'd1,
		S_START  = 3'd2,
		S_MOVE   = 3'd3,
		S_WON    = 3'd4
	} ctrl_state_e;

	typedef enum logic [1:0] {
		CMD_HOLD     = 2'd0,
		CMD_TO_START = 2'd1,
		CMD_STEP     = 2'd2
	} move_cmd_e;

	localparam int MAX_PATH = 11;
	localparam coord_t PLAYER_SIZE = 10'd25;

	localparam rgb_t COLOUR_PLAYER = '{4'hF, 4'h0, 4'hF};
	localparam rgb_t COLOUR_START  = '{4'h0, 4'hF, 4'h0};
	localparam rgb_t COLOUR_FINISH = '{4'hF, 4'h0, 4'h0};
	localparam rgb_t COLOUR_PATH   = '{4'hF, 4'hF, 4'hF};
	localparam rgb_t COLOUR_BLANK  = '{4'h0, 4'h0, 4'h0};

	// path slots per level, zero width marks an unused slot
	localparam rect_t PATH_RECTS [4][MAX_PATH] = '{
		'{default: '0},
		'{
			0: '{10'd100, 10'd100, 10'd50,  10'd380},
			1: '{10'd150, 10'd100, 10'd150, 10'd50},
			2: '{10'd300, 10'd100, 10'd50,  10'd380},
			3: '{10'd350, 10'd350, 10'd150, 10'd130},
			4: '{10'd500, 10'd0,   10'd140, 10'd480},
			default: '0
		},
		'{
			'{10'd20,  10'd100, 10'd50,  10'd380},
			'{10'd20,  10'd50,  10'd130, 10'd50},
			'{10'd100, 10'd100, 10'd50,  10'd350},
			'{10'd120, 10'd400, 10'd430, 10'd50},
			'{10'd500, 10'd100, 10'd50,  10'd300},
			'{10'd370, 10'd100, 10'd130, 10'd50},
			'{10'd320, 10'd100, 10'd50,  10'd170},
			'{10'd190, 10'd220, 10'd130, 10'd50},
			'{10'd190, 10'd30,  10'd50,  10'd190},
			'{10'd190, 10'd30,  10'd450, 10'd50},
			'{10'd590, 10'd55,  10'd50,  10'd425}
		},
		'{
			0: '{10'd0,   10'd90,  10'd160, 10'd300},
			1: '{10'd160, 10'd140, 10'd120, 10'd200},
			2: '{10'd280, 10'd190, 10'd120, 10'd100},
			3: '{10'd400, 10'd220, 10'd220, 10'd35},
			default: '0
		}
	};

	localparam rect_t START_RECT [4] = '{
		'0,
		'{10'd100, 10'd430, 10'd50, 10'd50},
		'{10'd20,  10'd430, 10'd50, 10'd50},
		'{10'd0,   10'd90,  10'd50, 10'd300}
	};

	localparam rect_t FINISH_RECT [4] = '{
		'0,
		'{10'd500, 10'd0,   10'd140, 10'd50},
		'{10'd590, 10'd430, 10'd50,  10'd50},
		'{10'd570, 10'd220, 10'd50,  10'd35}
	};

	localparam pos_t START_POS [4] = '{
		'0,
		'{10'd113, 10'd443},
		'{10'd33,  10'd443},
		'{10'd13,  10'd230}
	};

	// sums done in 11 bits so a wrapped player near 1023 stays sane
	function automatic logic rect_overlap(rect_t a, rect_t b);
		return ({1'b0, a.x} < {1'b0, b.x} + {1'b0, b.w})
			&& ({1'b0, b.x} < {1'b0, a.x} + {1'b0, a.w})
			&& ({1'b0, a.y} < {1'b0, b.y} + {1'b0, b.h})
			&& ({1'b0, b.y} < {1'b0, a.y} + {1'b0, a.h});
	endfunction

	function automatic logic point_in_rect(coord_t px, coord_t py, rect_t r);
		return (px >= r.x) && ({1'b0, px} < {1'b0, r.x} + {1'b0, r.w})
			&& (py >= r.y) && ({1'b0, py} < {1'b0, r.y} + {1'b0, r.h});
	endfunction

	function automatic rect_t player_rect(pos_t p);
		return '{p.x, p.y, PLAYER_SIZE, PLAYER_SIZE};
	endfunction

endpackage

/* hw/game_ctrl.sv */
`timescale 1ns/1ns

module game_ctrl
	import maze_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic [1:0]  level_select,
	input  logic        level_lock,
	input  logic        key0,
	input  logic        on_track,
	input  logic        at_finish,
	output level_t      level,
	output ctrl_state_e phase,
	output move_cmd_e   cmd,
	output logic        won
);

	ctrl_state_e phase_next;

	always_comb
	begin
		phase_next = phase;
		case (phase)
			S_IDLE:
			begin
				if (level_select != 2'b00)
					phase_next = S_SELECT;
			end
			S_SELECT:
			begin
				if (level_lock)
					phase_next = S_START;
			end
			S_START, S_MOVE, S_WON:
			begin
				// unlocking beats everything else in play
				if (!level_lock)
					phase_next = S_SELECT;
				else if (phase == S_START)
					phase_next = S_MOVE;
				else if (phase == S_MOVE)
				begin
					if (at_finish)
						phase_next = S_WON;
				end
				else if (!key0)
					phase_next = S_START;
			end
			default:
			begin
				phase_next = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			phase <= S_IDLE;
			level <= LEVEL_NONE;
		end
		else
		begin
			phase <= phase_next;
			// preview follows the selector until locked
			if (phase == S_SELECT)
				level <= level_t'(level_select);
		end
	end

	always_comb
	begin
		case (phase)
			S_SELECT, S_START:
			begin
				cmd = CMD_TO_START;
			end
			S_MOVE:
			begin
				cmd = on_track ? CMD_STEP : CMD_TO_START;
			end
			default:
			begin
				cmd = CMD_HOLD;
			end
		endcase
	end

	assign won = (phase == S_WON);

endmodule

/* hw/player_mover.sv */
`timescale 1ns/1ns

module player_mover
	import maze_pkg::*;
#(
	parameter int STEP = 5
)
(
	input  logic      clk,
	input  logic      rst,
	input  level_t    level,
	input  move_cmd_e cmd,
	input  logic [3:0] switches,
	output pos_t      pos
);

	localparam coord_t STEP_C = coord_t'(STEP);

	pos_t pos_step;

	// left, up, down, right; coordinates wrap at 1024
	always_comb
	begin
		pos_step = pos;
		if (switches[3])
			pos_step.x = pos.x - STEP_C;
		else if (switches[2])
			pos_step.y = pos.y - STEP_C;
		else if (switches[1])
			pos_step.y = pos.y + STEP_C;
		else if (switches[0])
			pos_step.x = pos.x + STEP_C;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pos <= '0;
		end
		else
		begin
			case (cmd)
				CMD_TO_START:
				begin
					pos <= START_POS[level];
				end
				CMD_STEP:
				begin
					pos <= pos_step;
				end
				default:
				begin
					pos <= pos;
				end
			endcase
		end
	end

endmodule

/* hw/track_checker.sv */
`timescale 1ns/1ns

module track_checker
	import maze_pkg::*;
(
	input  level_t level,
	input  pos_t   pos,
	output logic   on_track,
	output logic   at_finish
);

	rect_t player;
	rect_t path_slot;
	logic  hit_any;

	assign player = player_rect(pos);

	always_comb
	begin
		hit_any = 1'b0;
		path_slot = '0;
		for (int i = 0; i < MAX_PATH; i++)
		begin
			path_slot = PATH_RECTS[level][i];
			// empty slots never count
			if (path_slot.w != '0)
			begin
				if (rect_overlap(player, path_slot))
					hit_any = 1'b1;
			end
		end
	end

	assign on_track = hit_any;

	// finish of LEVEL_NONE is a zero rect and never overlaps
	assign at_finish = rect_overlap(player, FINISH_RECT[level]);

endmodule

/* hw/pixel_painter.sv */
`timescale 1ns/1ns

module pixel_painter
	import maze_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  level_t level,
	input  pos_t   pos,
	input  coord_t col,
	input  coord_t row,
	output rgb_t   colour
);

	rgb_t  colour_next;
	logic  in_path;
	rect_t player;

	assign player = player_rect(pos);

	always_comb
	begin
		in_path = 1'b0;
		for (int i = 0; i < MAX_PATH; i++)
		begin
			if (PATH_RECTS[level][i].w != '0)
			begin
				if (point_in_rect(col, row, PATH_RECTS[level][i]))
					in_path = 1'b1;
			end
		end
	end

	// first match wins
	always_comb
	begin
		if (level == LEVEL_NONE)
			colour_next = COLOUR_BLANK;
		else if (point_in_rect(col, row, player))
			colour_next = COLOUR_PLAYER;
		else if (point_in_rect(col, row, START_RECT[level]))
			colour_next = COLOUR_START;
		else if (point_in_rect(col, row, FINISH_RECT[level]))
			colour_next = COLOUR_FINISH;
		else if (in_path)
			colour_next = COLOUR_PATH;
		else
			colour_next = COLOUR_BLANK;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			colour <= COLOUR_BLANK;
		else
			colour <= colour_next;
	end

endmodule

/* hw/maze_game.sv */
`timescale 1ns/1ns

module maze_game
	import maze_pkg::*;
#(
	parameter int STEP = 5
)
(
	input  logic       clk,
	input  logic       rst,
	input  logic [1:0] level_select,
	input  logic       level_lock,
	input  logic       key0,
	input  logic [3:0] switches,
	input  coord_t     col,
	input  coord_t     row,
	output rgb_t       colour,
	output logic       won
);

	level_t      level;
	ctrl_state_e phase;
	move_cmd_e   cmd;
	pos_t        pos;
	logic        on_track;
	logic        at_finish;

	game_ctrl i_game_ctrl (
		.clk          (clk),
		.rst          (rst),
		.level_select (level_select),
		.level_lock   (level_lock),
		.key0         (key0),
		.on_track     (on_track),
		.at_finish    (at_finish),
		.level        (level),
		.phase        (phase),
		.cmd          (cmd),
		.won          (won)
	);

	player_mover #(
		.STEP (STEP)
	) i_player_mover (
		.clk      (clk),
		.rst      (rst),
		.level    (level),
		.cmd      (cmd),
		.switches (switches),
		.pos      (pos)
	);

	track_checker i_track_checker (
		.level     (level),
		.pos       (pos),
		.on_track  (on_track),
		.at_finish (at_finish)
	);

	pixel_painter i_pixel_painter (
		.clk    (clk),
		.rst    (rst),
		.level  (level),
		.pos    (pos),
		.col    (col),
		.row    (row),
		.colour (colour)
	);

endmodule

/* test/maze_model.svh */
`ifndef MAZE_MODEL_SVH
`define MAZE_MODEL_SVH

// reference copies of the controller, mover and painter registers
ctrl_state_e m_phase;
level_t      m_level;
pos_t        m_pos;
rgb_t        m_colour;
coord_t      m_col;
coord_t      m_row;
int          m_returns;

// half-open spans [a0, a0+alen) and [b0, b0+blen) share a value
function automatic bit span_hit(coord_t a0, coord_t alen, coord_t b0, coord_t blen);
	return (int'(a0) < int'(b0) + int'(blen)) && (int'(b0) < int'(a0) + int'(alen));
endfunction

function automatic bit rects_meet(rect_t a, rect_t b);
	return span_hit(a.x, a.w, b.x, b.w) && span_hit(a.y, a.h, b.y, b.h);
endfunction

function automatic bit any_path(level_t lv, rect_t probe);
	bit hit;
	hit = 1'b0;
	for (int i = 0; i < MAX_PATH; i++)
		if (PATH_RECTS[lv][i].w != 10'd0 && rects_meet(probe, PATH_RECTS[lv][i]))
			hit = 1'b1;
	return hit;
endfunction

function automatic rgb_t paint(level_t lv, pos_t p, coord_t c, coord_t r);
	rect_t px;
	rect_t sq;
	px = '{c, r, 10'd1, 10'd1};
	sq = '{p.x, p.y, PLAYER_SIZE, PLAYER_SIZE};
	if (lv == LEVEL_NONE)
		return COLOUR_BLANK;
	if (rects_meet(px, sq))
		return COLOUR_PLAYER;
	if (rects_meet(px, START_RECT[lv]))
		return COLOUR_START;
	if (rects_meet(px, FINISH_RECT[lv]))
		return COLOUR_FINISH;
	if (any_path(lv, px))
		return COLOUR_PATH;
	return COLOUR_BLANK;
endfunction

task automatic model_step();
	ctrl_state_e nphase;
	level_t      nlevel;
	pos_t        npos;
	rect_t       sq;
	if (rst)
	begin
		m_phase = S_IDLE;
		m_level = LEVEL_NONE;
		m_pos = '0;
		m_colour = COLOUR_BLANK;
		m_returns = 0;
		return;
	end
	sq = '{m_pos.x, m_pos.y, PLAYER_SIZE, PLAYER_SIZE};
	m_colour = paint(m_level, m_pos, col, row);
	m_col = col;
	m_row = row;
	nphase = m_phase;
	nlevel = m_level;
	npos = m_pos;
	case (m_phase)
		S_IDLE:
			if (level_select != 2'b00)
				nphase = S_SELECT;
		S_SELECT:
		begin
			nlevel = level_t'(level_select);
			npos = START_POS[m_level];
			if (level_lock)
				nphase = S_START;
		end
		S_START:
		begin
			npos = START_POS[m_level];
			nphase = level_lock ? S_MOVE : S_SELECT;
		end
		S_MOVE:
		begin
			if (!any_path(m_level, sq))
			begin
				npos = START_POS[m_level];
				m_returns++;
			end
			else if (switches[3])
				npos.x = m_pos.x - coord_t'(STEP);
			else if (switches[2])
				npos.y = m_pos.y - coord_t'(STEP);
			else if (switches[1])
				npos.y = m_pos.y + coord_t'(STEP);
			else if (switches[0])
				npos.x = m_pos.x + coord_t'(STEP);
			if (!level_lock)
				nphase = S_SELECT;
			else if (rects_meet(sq, FINISH_RECT[m_level]))
				nphase = S_WON;
		end
		default:
			if (!level_lock)
				nphase = S_SELECT;
			else if (!key0)
				nphase = S_START;
	endcase
	m_phase = nphase;
	m_level = nlevel;
	m_pos = npos;
endtask

`endif

/* test/maze_game_tb.sv */
`timescale 1ns/1ns

module maze_game_tb
	import maze_pkg::*;
();

	localparam int STEP = 5;
	localparam int MAX_CYCLES = 12000;

	logic       clk = 1'b0;
	logic       rst;
	logic [1:0] level_select;
	logic       level_lock;
	logic       key0;
	logic [3:0] switches;
	coord_t     col;
	coord_t     row;
	rgb_t       colour;
	logic       won;

	int          errors = 0;
	int          seq_errors = 0;
	int          checks = 0;
	int          cycles = 0;
	logic [31:0] lcg_state;

	`include "maze_model.svh"

	maze_game #(
		.STEP (STEP)
	) i_dut (
		.clk          (clk),
		.rst          (rst),
		.level_select (level_select),
		.level_lock   (level_lock),
		.key0         (key0),
		.switches     (switches),
		.col          (col),
		.row          (row),
		.colour       (colour),
		.won          (won)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		model_step();

	// outputs are settled by the falling edge
	always @(negedge clk)
	begin
		checks++;
		if (colour !== m_colour)
		begin
			errors++;
			$display("MISMATCH at %0t: colour %h expected %h at col %0d row %0d",
				$time, colour, m_colour, m_col, m_row);
		end
		if (won !== (m_phase == S_WON))
		begin
			errors++;
			$display("MISMATCH at %0t: won %b expected %b", $time, won, m_phase == S_WON);
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: run still going after %0d cycles, %0d errors so far",
				MAX_CYCLES, errors + seq_errors);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic int rand_below(int n);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[30:16]) % n;
	endfunction

	// mostly one direction at a time
	function automatic logic [3:0] rand_sw();
		int n;
		n = rand_below(8);
		if (n < 4)
			return 4'b0001 << n;
		return 4'(rand_below(16));
	endfunction

	task automatic drive_cycle(logic [1:0] sel, logic lock, logic key, logic [3:0] sw, bit near);
		@(posedge clk);
		#2;
		level_select = sel;
		level_lock = lock;
		key0 = key;
		switches = sw;
		if (near)
		begin
			col = coord_t'(m_pos.x + rand_below(35) - 5);
			row = coord_t'(m_pos.y + rand_below(35) - 5);
		end
		else
		begin
			col = coord_t'(rand_below(640));
			row = coord_t'(rand_below(480));
		end
	endtask

	// level 3 is a straight run to the right from its start
	task automatic reach_finish();
		int steps;
		steps = 0;
		repeat (4) drive_cycle(2'd3, 1'b0, 1'b1, 4'd0, 1'b0);
		while (won !== 1'b1 && steps < 200)
		begin
			drive_cycle(2'd3, 1'b1, 1'b1, 4'b0001, 1'b1);
			steps++;
		end
		if (won !== 1'b1 || m_phase != S_WON)
		begin
			seq_errors++;
			$display("run to the finish ended after %0d steps without reaching the won state",
				steps);
		end
	endtask

	initial
	begin
		logic [1:0] sel;
		rst = 1'b1;
		level_select = 2'b00;
		level_lock = 1'b0;
		key0 = 1'b1;
		switches = 4'd0;
		col = '0;
		row = '0;
		lcg_state = 32'd74054;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		repeat (200) drive_cycle(2'd0, 1'b0, 1'b1, rand_sw(), 1'b0);
		// preview with lock low
		repeat (3)
		begin
			sel = 2'(rand_below(3) + 1);
			repeat (300) drive_cycle(sel, 1'b0, 1'b1, rand_sw(), rand_below(4) == 0);
		end
		// each round unlocks, picks a level and plays
		repeat (9)
		begin
			sel = 2'(rand_below(3) + 1);
			repeat (4) drive_cycle(sel, 1'b0, 1'b1, 4'd0, 1'b0);
			repeat (900) drive_cycle(sel, 1'b1, rand_below(8) != 0, rand_sw(), rand_below(4) != 0);
		end
		reach_finish();
		repeat (20) drive_cycle(2'd3, 1'b1, 1'b1, rand_sw(), 1'b1);
		drive_cycle(2'd3, 1'b1, 1'b0, 4'd0, 1'b1);
		repeat (20) drive_cycle(2'd3, 1'b1, 1'b1, 4'd0, 1'b1);
		reach_finish();
		repeat (10) drive_cycle(2'd3, 1'b1, 1'b1, 4'd0, 1'b1);
		// unlock while won, then a new preview
		repeat (50) drive_cycle(2'd1, 1'b0, 1'b1, 4'd0, rand_below(2) == 0);
		// unlock straight out of the start state
		drive_cycle(2'd1, 1'b1, 1'b1, 4'd0, 1'b1);
		repeat (10) drive_cycle(2'd2, 1'b0, 1'b1, 4'd0, rand_below(2) == 0);
		if (m_returns == 0)
		begin
			seq_errors++;
			$display("the player never left the track, return to start was not exercised");
		end
		repeat (2) drive_cycle(2'd0, 1'b0, 1'b1, 4'd0, 1'b0);
		$display("checks: %0d, value errors: %0d, sequence errors: %0d",
			checks, errors, seq_errors);
		if (errors == 0 && seq_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* maze_game.f */
+incdir+test
hw/maze_pkg.sv
hw/game_ctrl.sv
hw/player_mover.sv
hw/track_checker.sv
hw/pixel_painter.sv
hw/maze_game.sv
test/maze_game_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module maze_game_tb \
	-f maze_game.f \
	-o maze_game_sim

./obj_dir/maze_game_sim | tee sim.log

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
